// File: common/lspcVideoPkg.sv
package lspcVideoPkg;

	// Pixels per line at 6 MHz
	localparam int lineLength = 384;

	// Pixels of horizontal sync at the start of each line
	localparam int syncPixels = 28;

	// Vertical range, 264 lines per frame
	localparam logic [8:0] firstLine = 9'h0F8;
	localparam logic [8:0] lastLine = 9'h1FF;

	// Active display sits between these two lines
	localparam logic [8:0] vblankEnd = 9'h110;
	localparam logic [8:0] vblankStart = 9'h1F0;

	typedef struct packed
	{
		logic [8:0] vcount;
		logic [8:0] hcount;
		logic pixelEn;
		logic vblank;
		logic frameStart;
	} rasterStatus;

	// Bit 0 is reloadOnLoad, as in the mode register
	typedef struct packed
	{
		logic reloadOnZero;
		logic reloadOnFrame;
		logic reloadOnLoad;
	} timerMode;

endpackage

// File: common/lspcCpuPkg.sv
package lspcCpuPkg;

	// Register window, one index per CPU word address
	localparam logic [2:0] regVramAddr = 3'd0;
	localparam logic [2:0] regVramData = 3'd1;
	localparam logic [2:0] regVramMod = 3'd2;
	localparam logic [2:0] regMode = 3'd3;
	localparam logic [2:0] regTimerHigh = 3'd4;
	localparam logic [2:0] regTimerLow = 3'd5;
	localparam logic [2:0] regIrqAck = 3'd6;
	localparam logic [2:0] regTimerStop = 3'd7;

	// Zone bit selects the upper VRAM area
	typedef struct packed
	{
		logic zone;
		logic [14:0] addr;
	} vramPtrView;

	typedef struct packed
	{
		logic [7:0] aaSpeed;
		logic [2:0] timerMode;
		logic timerEn;
		logic aaDisable;
		logic [2:0] unused;
	} modeView;

	// Same bus word, decoded by register index
	typedef union packed
	{
		logic [15:0] raw;
		vramPtrView vramPtr;
		modeView modeWrite;
	} regWord;

	// Payload of one VRAM transaction
	typedef struct packed
	{
		logic write;
		logic [15:0] addr;
		logic [15:0] data;
	} vramReq;

endpackage

// File: lspcControl/lspcControl.sv
`timescale 1ns/1ps

module lspcControl #(
	parameter bit palMode = 1'b1
) (
	input logic CLK_24M,
	input logic nRESET,
	input logic [2:0] cpuAddr,
	input lspcCpuPkg::regWord cpuDataIn,
	input logic cpuWr,
	input logic cpuRd,
	input lspcVideoPkg::rasterStatus raster,
	input logic timerIrq,
	input logic [2:0] aaCount,
	input logic ack,
	input logic [15:0] rdData,
	output logic [15:0] cpuDataOut,
	output logic ipl0,
	output logic ipl1,
	output logic req,
	output lspcCpuPkg::vramReq vramReq,
	output logic [31:0] loadValue,
	output logic loadStrobe,
	output lspcVideoPkg::timerMode timerMode,
	output logic timerEn,
	output logic timerStop,
	output logic [7:0] aaSpeed,
	output logic aaDisable
);
	import lspcCpuPkg::*;

	vramPtrView vramPtr;
	logic [15:0] vramMod;
	logic [15:0] readBuf;
	logic busy;
	logic vramStart;
	logic stopReg;
	// Pending flags: coldboot, timer, VBL
	logic [2:0] irqFlags;
	logic [2:0] irqClear;

	assign vramStart = cpuWr && !busy && (cpuAddr == regVramAddr || cpuAddr == regVramData);
	assign irqClear = (cpuWr && cpuAddr == regIrqAck) ? cpuDataIn.raw[2:0] : 3'b000;

	// Border stop only exists on PAL
	assign timerStop = stopReg & palMode;

	always_ff @(posedge CLK_24M)
	begin
		if (!nRESET)
		begin
			req <= 1'b0;
			busy <= 1'b0;
			irqFlags <= 3'b100;
			loadStrobe <= 1'b0;
			timerMode <= '0;
			timerEn <= 1'b0;
			stopReg <= 1'b0;
			aaSpeed <= 8'h00;
			aaDisable <= 1'b0;
		end
		else
		begin
			loadStrobe <= 1'b0;
			// New events win over an ack in the same cycle
			irqFlags <= (irqFlags & ~irqClear) | {1'b0, timerIrq, raster.frameStart};

			// Four-phase master: drop req on ack, free up once ack is low again
			if (req && ack)
				req <= 1'b0;
			else if (busy && !req && !ack)
				busy <= 1'b0;

			if (vramStart)
			begin
				req <= 1'b1;
				busy <= 1'b1;
			end

			if (cpuWr)
			begin
				case (cpuAddr)
					regMode:
					begin
						aaSpeed <= cpuDataIn.modeWrite.aaSpeed;
						timerMode <= cpuDataIn.modeWrite.timerMode;
						timerEn <= cpuDataIn.modeWrite.timerEn;
						aaDisable <= cpuDataIn.modeWrite.aaDisable;
					end
					regTimerLow: loadStrobe <= 1'b1;
					regTimerStop: stopReg <= cpuDataIn.raw[0];
					default: ;
				endcase
			end
		end
	end

	// Pointer, buffers and read data
	always_ff @(posedge CLK_24M)
	begin
		if (req && ack && !vramReq.write)
			readBuf <= rdData;

		if (cpuWr)
		begin
			case (cpuAddr)
				regVramAddr:
				begin
					// Setting the pointer fetches that word
					if (!busy)
					begin
						vramPtr <= cpuDataIn.vramPtr;
						vramReq.write <= 1'b0;
						vramReq.addr <= cpuDataIn.raw;
						vramReq.data <= 16'h0000;
					end
				end
				regVramData:
				begin
					if (!busy)
					begin
						vramReq.write <= 1'b1;
						vramReq.addr <= vramPtr;
						vramReq.data <= cpuDataIn.raw;
						vramPtr.addr <= vramPtr.addr + vramMod[14:0];
					end
				end
				regVramMod: vramMod <= cpuDataIn.raw;
				regTimerHigh: loadValue[31:16] <= cpuDataIn.raw;
				regTimerLow: loadValue[15:0] <= cpuDataIn.raw;
				default: ;
			endcase
		end

		if (cpuRd)
		begin
			case (cpuAddr)
				regVramAddr, regVramData: cpuDataOut <= readBuf;
				regVramMod: cpuDataOut <= vramMod;
				regMode: cpuDataOut <= {raster.vcount, 3'b000, palMode, aaCount};
				default: cpuDataOut <= 16'h0000;
			endcase
		end
	end

	// Coldboot over timer over VBL, pins active low
	always_comb
	begin
		if (irqFlags[2])
			{ipl1, ipl0} = 2'b00;
		else if (irqFlags[1])
			{ipl1, ipl0} = 2'b01;
		else if (irqFlags[0])
			{ipl1, ipl0} = 2'b10;
		else
			{ipl1, ipl0} = 2'b11;
	end

endmodule

// File: rtl/rasterCounter.sv
`timescale 1ns/1ps

module rasterCounter (
	input logic CLK_24M,
	input logic nRESET,
	output lspcVideoPkg::rasterStatus raster,
	output logic sync
);
	import lspcVideoPkg::*;

	logic [1:0] clkDiv;
	logic [8:0] hcount;
	logic [8:0] vcount;
	logic frameStart;
	logic pixelEn;
	logic lineEnd;

	// One pixel every fourth 24 MHz cycle
	assign pixelEn = (clkDiv == 2'd3);
	assign lineEnd = pixelEn && (hcount == 9'(lineLength - 1));

	always_ff @(posedge CLK_24M)
	begin
		if (!nRESET)
		begin
			clkDiv <= 2'd0;
			hcount <= 9'd0;
			vcount <= firstLine;
			frameStart <= 1'b0;
			sync <= 1'b1;
		end
		else
		begin
			clkDiv <= clkDiv + 2'd1;
			frameStart <= 1'b0;
			if (lineEnd)
			begin
				hcount <= 9'd0;
				sync <= 1'b0;
				if (vcount == lastLine)
					vcount <= firstLine;
				else
					vcount <= vcount + 9'd1;
				// Pulse as the next line becomes vblankStart
				frameStart <= (vcount == vblankStart - 9'd1);
			end
			else if (pixelEn)
			begin
				hcount <= hcount + 9'd1;
				sync <= (hcount >= 9'(syncPixels - 1));
			end
		end
	end

	always_comb
	begin
		raster.vcount = vcount;
		raster.hcount = hcount;
		raster.pixelEn = pixelEn;
		raster.vblank = (vcount >= vblankStart) || (vcount < vblankEnd);
		raster.frameStart = frameStart;
	end

endmodule

// File: rtl/pixelTimer.sv
`timescale 1ns/1ps

module pixelTimer (
	input logic CLK_24M,
	input logic nRESET,
	input lspcVideoPkg::rasterStatus raster,
	input logic [31:0] loadValue,
	input logic loadStrobe,
	input lspcVideoPkg::timerMode timerMode,
	input logic timerEn,
	input logic timerStop,
	output logic timerIrq
);

	logic [31:0] count;
	logic border;
	logic run;

	// Top lines 0x100-0x10F and bottom lines 0x1F0-0x1FF
	assign border = (raster.vcount[7:4] == 4'h0) || (raster.vcount[7:4] == 4'hF);

	// Counts only on the lines with vcount bit 8 set
	assign run = raster.pixelEn && raster.vcount[8] && !(timerStop && border);

	always_ff @(posedge CLK_24M)
	begin
		if (!nRESET)
		begin
			count <= 32'd0;
			timerIrq <= 1'b0;
		end
		else
		begin
			timerIrq <= 1'b0;
			if (loadStrobe && timerMode.reloadOnLoad)
				count <= loadValue;
			else if (raster.frameStart && timerMode.reloadOnFrame)
				count <= loadValue;
			else if (run)
			begin
				if (count != 32'd0)
					count <= count - 32'd1;
				else
				begin
					timerIrq <= timerEn;
					if (timerMode.reloadOnZero)
						count <= loadValue;
				end
			end
		end
	end

endmodule

// File: rtl/autoAnim.sv
`timescale 1ns/1ps

module autoAnim (
	input logic CLK_24M,
	input logic nRESET,
	input lspcVideoPkg::rasterStatus raster,
	input logic [7:0] aaSpeed,
	input logic aaDisable,
	output logic [2:0] aaCount
);

	// Frames seen since the last step
	logic [7:0] frameCnt;

	always_ff @(posedge CLK_24M)
	begin
		if (!nRESET)
		begin
			frameCnt <= 8'd0;
			aaCount <= 3'd0;
		end
		else if (raster.frameStart && !aaDisable)
		begin
			// aaSpeed 0 steps every frame
			if (frameCnt >= aaSpeed)
			begin
				frameCnt <= 8'd0;
				aaCount <= aaCount + 3'd1;
			end
			else
				frameCnt <= frameCnt + 8'd1;
		end
	end

endmodule

// File: rtl/vramPort.sv
`timescale 1ns/1ps

module vramPort (
	input logic CLK_24M,
	input logic nRESET,
	input logic req,
	input lspcCpuPkg::vramReq vramReq,
	output logic ack,
	output logic [15:0] rdData
);

	// Lower VRAM zone only, 32K words
	logic [15:0] mem [0:32767];
	logic delay;
	logic access;

	// Second cycle of a seen req does the access
	assign access = req && !ack && delay;

	always_ff @(posedge CLK_24M)
	begin
		if (!nRESET)
		begin
			ack <= 1'b0;
			delay <= 1'b0;
		end
		else if (req && !ack)
		begin
			if (delay)
			begin
				ack <= 1'b1;
				delay <= 1'b0;
			end
			else
				delay <= 1'b1;
		end
		else if (!req)
		begin
			// Release ack only after the master drops req
			ack <= 1'b0;
			delay <= 1'b0;
		end
	end

	always_ff @(posedge CLK_24M)
	begin
		if (access)
		begin
			if (vramReq.write)
				mem[vramReq.addr[14:0]] <= vramReq.data;
			rdData <= mem[vramReq.addr[14:0]];
		end
	end

endmodule

// File: rtl/lspcTop.sv
`timescale 1ns/1ps

module lspcTop #(
	parameter bit palMode = 1'b1
) (
	input logic CLK_24M,
	input logic nRESET,
	input logic [2:0] cpuAddr,
	input lspcCpuPkg::regWord cpuDataIn,
	input logic cpuWr,
	input logic cpuRd,
	output logic [15:0] cpuDataOut,
	output logic ipl0,
	output logic ipl1,
	output logic sync
);
	import lspcVideoPkg::*;
	import lspcCpuPkg::*;

	rasterStatus raster;
	timerMode timerCfg;
	vramReq vramPayload;

	logic req;
	logic ack;
	logic [15:0] rdData;
	logic [31:0] loadValue;
	logic loadStrobe;
	logic timerEn;
	logic timerStop;
	logic timerIrq;
	logic [7:0] aaSpeed;
	logic aaDisable;
	logic [2:0] aaCount;

	lspcControl #(
		.palMode(palMode)
	) control (
		.CLK_24M(CLK_24M),
		.nRESET(nRESET),
		.cpuAddr(cpuAddr),
		.cpuDataIn(cpuDataIn),
		.cpuWr(cpuWr),
		.cpuRd(cpuRd),
		.raster(raster),
		.timerIrq(timerIrq),
		.aaCount(aaCount),
		.ack(ack),
		.rdData(rdData),
		.cpuDataOut(cpuDataOut),
		.ipl0(ipl0),
		.ipl1(ipl1),
		.req(req),
		.vramReq(vramPayload),
		.loadValue(loadValue),
		.loadStrobe(loadStrobe),
		.timerMode(timerCfg),
		.timerEn(timerEn),
		.timerStop(timerStop),
		.aaSpeed(aaSpeed),
		.aaDisable(aaDisable)
	);

	rasterCounter raster0 (
		.CLK_24M(CLK_24M),
		.nRESET(nRESET),
		.raster(raster),
		.sync(sync)
	);

	pixelTimer timer0 (
		.CLK_24M(CLK_24M),
		.nRESET(nRESET),
		.raster(raster),
		.loadValue(loadValue),
		.loadStrobe(loadStrobe),
		.timerMode(timerCfg),
		.timerEn(timerEn),
		.timerStop(timerStop),
		.timerIrq(timerIrq)
	);

	autoAnim anim0 (
		.CLK_24M(CLK_24M),
		.nRESET(nRESET),
		.raster(raster),
		.aaSpeed(aaSpeed),
		.aaDisable(aaDisable),
		.aaCount(aaCount)
	);

	vramPort vram0 (
		.CLK_24M(CLK_24M),
		.nRESET(nRESET),
		.req(req),
		.vramReq(vramPayload),
		.ack(ack),
		.rdData(rdData)
	);

endmodule

// File: test/lspcTb_checker.sv
`timescale 1ns/1ps

module lspcTb_checker (
	input logic CLK_24M,
	input logic nRESET,
	input logic [2:0] cpuAddr,
	input lspcCpuPkg::regWord cpuDataIn,
	input logic cpuWr,
	input lspcVideoPkg::rasterStatus raster,
	input logic timerIrq,
	input logic req,
	input logic ack,
	input lspcCpuPkg::vramReq vramReq,
	input logic [2:0] irqFlags,
	input logic ipl0,
	input logic ipl1
);
	import lspcCpuPkg::*;

	// Four-phase ordering between req and ack
	reqRise: assert property (@(posedge CLK_24M) disable iff (!nRESET) $rose(req) |-> !ack)
		else $error("req rose while ack was still high");
	ackRise: assert property (@(posedge CLK_24M) disable iff (!nRESET) $rose(ack) |-> req)
		else $error("ack rose without a pending req");
	reqFall: assert property (@(posedge CLK_24M) disable iff (!nRESET) $fell(req) |-> ack)
		else $error("req fell before ack was seen");
	ackFall: assert property (@(posedge CLK_24M) disable iff (!nRESET) $fell(ack) |-> !req)
		else $error("ack fell while req was still high");

	payloadStable: assert property (@(posedge CLK_24M) disable iff (!nRESET)
		req && $past(req) |-> $stable(vramReq))
		else $error("VRAM payload changed while req was high");

	// Acknowledging every pending flag with no new event releases both pins
	iplIdle: assert property (@(posedge CLK_24M) disable iff (!nRESET)
		cpuWr && cpuAddr == regIrqAck && (irqFlags & ~cpuDataIn.raw[2:0]) == 3'b000
		&& !timerIrq && !raster.frameStart |=> ipl0 && ipl1)
		else $error("ipl driven low with no pending interrupt");

	resetState: assert property (@(posedge CLK_24M)
		!nRESET |=> !req && !ack && irqFlags == 3'b100)
		else $error("handshake or interrupt flags wrong after reset");

endmodule

bind lspcControl lspcTb_checker checker0 (
	.CLK_24M(CLK_24M),
	.nRESET(nRESET),
	.cpuAddr(cpuAddr),
	.cpuDataIn(cpuDataIn),
	.cpuWr(cpuWr),
	.raster(raster),
	.timerIrq(timerIrq),
	.req(req),
	.ack(ack),
	.vramReq(vramReq),
	.irqFlags(irqFlags),
	.ipl0(ipl0),
	.ipl1(ipl1)
);

// File: test/lspcTb.sv
`timescale 1ns/1ps

module lspcTb;
	import lspcCpuPkg::*;
	import lspcVideoPkg::*;

	// 384 pixels by 264 lines, four clocks per pixel
	localparam int frameCycles = lineLength * (int'(lastLine) - int'(firstLine) + 1) * 4;
	localparam int cycleLimit = 3 * frameCycles + 5000;
	localparam int lineCycles = lineLength * 4;
	// 28 pixels of sync, four clocks each
	localparam int syncLowCycles = 28 * 4;

	localparam logic [2:0] opWrite = 3'd0;
	localparam logic [2:0] opRead = 3'd1;
	localparam logic [2:0] opIpl = 3'd2;
	localparam logic [2:0] opWaitIpl = 3'd3;
	localparam logic [2:0] opVcount = 3'd4;
	localparam logic [2:0] opAaMark = 3'd5;
	localparam logic [2:0] opAaDelta = 3'd6;
	localparam logic [2:0] opSync = 3'd7;

	typedef struct packed
	{
		logic [2:0] op;
		logic [2:0] addr;
		logic [15:0] data;
		logic [15:0] expected;
		logic [15:0] mask;
	} tableStep;

	logic CLK_24M;
	logic nRESET;
	logic [2:0] cpuAddr;
	regWord cpuDataIn;
	logic cpuWr;
	logic cpuRd;
	logic [15:0] cpuDataOut;
	logic ipl0;
	logic ipl1;
	logic sync;

	tableStep steps[$];
	string stepNames[$];
	logic [15:0] vramWords [0:10];
	logic [2:0] aaMarked;
	int cycles = 0;

	lspcTop #(
		.palMode(1'b1)
	) uut (
		.CLK_24M(CLK_24M),
		.nRESET(nRESET),
		.cpuAddr(cpuAddr),
		.cpuDataIn(cpuDataIn),
		.cpuWr(cpuWr),
		.cpuRd(cpuRd),
		.cpuDataOut(cpuDataOut),
		.ipl0(ipl0),
		.ipl1(ipl1),
		.sync(sync)
	);

	initial
	begin
		CLK_24M = 1'b0;
		forever #20 CLK_24M = ~CLK_24M;
	end

	task automatic reportFailure(string msg);
		$display("%s", msg);
		$display("Result: FAILED");
		$fatal(1, "Simulation stopped on the first error");
	endtask

	always @(posedge CLK_24M)
	begin
		cycles <= cycles + 1;
		if (cycles >= cycleLimit)
			reportFailure($sformatf("Timeout: run did not finish within %0d cycles", cycleLimit));
	end

	function automatic logic [31:0] xorshift(logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	// Mode register word from its fields
	function automatic logic [15:0] modeWord(logic [7:0] speed, logic [2:0] mode, logic en,
		logic dis);
		regWord w;
		w.raw = 16'h0000;
		w.modeWrite.aaSpeed = speed;
		w.modeWrite.timerMode = mode;
		w.modeWrite.timerEn = en;
		w.modeWrite.aaDisable = dis;
		return w.raw;
	endfunction

	task automatic checkWord(string testName, regWord expected, regWord actual);
		if (actual.raw !== expected.raw)
			reportFailure($sformatf("ERROR %s: expected %h, actual %h", testName,
				expected.raw, actual.raw));
	endtask

	task automatic checkIpl(string testName, logic [1:0] expected, logic [1:0] actual);
		if (actual !== expected)
			reportFailure($sformatf("ERROR %s: expected ipl %b, actual ipl %b", testName,
				expected, actual));
	endtask

	task automatic checkSyncLength(string testName, int expected, int actual);
		if (actual != expected)
			reportFailure($sformatf("ERROR %s: expected %0d sync low cycles, actual %0d",
				testName, expected, actual));
	endtask

	task automatic addStep(logic [2:0] op, logic [2:0] addr, logic [15:0] data,
		logic [15:0] expected, logic [15:0] mask, string testName);
		tableStep s;
		s.op = op;
		s.addr = addr;
		s.data = data;
		s.expected = expected;
		s.mask = mask;
		steps.push_back(s);
		stepNames.push_back(testName);
	endtask

	task automatic writeReg(logic [2:0] addr, logic [15:0] data);
		cpuAddr = addr;
		cpuDataIn.raw = data;
		cpuWr = 1'b1;
		@(negedge CLK_24M);
		cpuWr = 1'b0;
		// VRAM accesses must be at least 8 cycles apart
		if (addr == regVramAddr || addr == regVramData)
			repeat (8) @(negedge CLK_24M);
	endtask

	task automatic readReg(logic [2:0] addr, output regWord value);
		cpuAddr = addr;
		cpuRd = 1'b1;
		@(negedge CLK_24M);
		cpuRd = 1'b0;
		value = cpuDataOut;
	endtask

	task automatic waitForIpl(string testName, logic [1:0] expected);
		int waited;
		waited = 0;
		while ({ipl1, ipl0} != expected)
		begin
			if (waited > frameCycles)
				reportFailure($sformatf("%s: interrupt level %b did not arrive within a frame",
					testName, expected));
			else
			begin
				@(negedge CLK_24M);
				waited++;
			end
		end
	endtask

	task automatic applyStep(tableStep s, string testName);
		regWord value;
		regWord expectedWord;
		int lowCycles;
		case (s.op)
			opWrite: writeReg(s.addr, s.data);
			opRead:
			begin
				readReg(s.addr, value);
				value.raw = value.raw & s.mask;
				expectedWord.raw = s.expected & s.mask;
				checkWord(testName, expectedWord, value);
			end
			opIpl: checkIpl(testName, s.expected[1:0], {ipl1, ipl0});
			opWaitIpl: waitForIpl(testName, s.expected[1:0]);
			opVcount:
			begin
				// vcount sits in bits 15:7 of the mode register
				readReg(regMode, value);
				if (value.raw[15:7] < firstLine || value.raw[15:7] > lastLine)
					reportFailure($sformatf("%s: vcount %h is outside the frame", testName,
						value.raw[15:7]));
			end
			opAaMark:
			begin
				readReg(regMode, value);
				aaMarked = value.raw[2:0];
			end
			opAaDelta:
			begin
				readReg(regMode, value);
				value.raw = {13'd0, value.raw[2:0]};
				expectedWord.raw = {13'd0, 3'(aaMarked + s.data[2:0])};
				checkWord(testName, expectedWord, value);
			end
			opSync:
			begin
				// Count low cycles over one whole line
				lowCycles = 0;
				repeat (lineCycles)
				begin
					@(negedge CLK_24M);
					if (sync === 1'b0)
						lowCycles++;
				end
				checkSyncLength(testName, int'(s.expected), lowCycles);
			end
			default: reportFailure("Unknown step kind in the stimulus table");
		endcase
	endtask

	task automatic buildTable();
		logic [31:0] x;
		x = 32'd88611;
		for (int i = 0; i < 11; i++)
		begin
			x = xorshift(x);
			vramWords[i] = x[15:0];
		end

		// Only coldboot pending after reset
		addStep(opIpl, 0, 0, 16'h0000, 0, "coldboot");
		addStep(opWrite, regIrqAck, 16'h0004, 0, 0, "coldboot");
		addStep(opIpl, 0, 0, 16'h0003, 0, "coldboot");

		addStep(opWrite, regVramMod, 16'h1234, 0, 0, "vramMod");
		addStep(opRead, regVramMod, 0, 16'h1234, 16'hFFFF, "vramMod");
		addStep(opWrite, regVramMod, 16'h0001, 0, 0, "vramMod");
		addStep(opRead, regVramMod, 0, 16'h0001, 16'hFFFF, "vramMod");

		addStep(opWrite, regVramAddr, 16'h0100, 0, 0, "vramLinear");
		for (int i = 0; i < 8; i++)
			addStep(opWrite, regVramData, vramWords[i], 0, 0, "vramLinear");
		for (int i = 0; i < 8; i++)
		begin
			addStep(opWrite, regVramAddr, 16'h0100 + 16'(i), 0, 0, "vramLinear");
			addStep(opRead, regVramData, 0, vramWords[i], 16'hFFFF, "vramLinear");
		end

		// Stride of 0x20 between stored words
		addStep(opWrite, regVramMod, 16'h0020, 0, 0, "vramStride");
		addStep(opWrite, regVramAddr, 16'h0400, 0, 0, "vramStride");
		for (int i = 8; i < 11; i++)
			addStep(opWrite, regVramData, vramWords[i], 0, 0, "vramStride");
		for (int i = 0; i < 3; i++)
		begin
			addStep(opWrite, regVramAddr, 16'h0400 + 16'(i * 32), 0, 0, "vramStride");
			addStep(opRead, regVramData, 0, vramWords[8 + i], 16'hFFFF, "vramStride");
		end

		// PAL bit set, three zero bits, aaCount still zero
		addStep(opRead, regMode, 0, 16'h0008, 16'h007F, "modeRead");
		addStep(opVcount, 0, 0, 0, 0, "modeRead");

		// Sync low for the first 28 pixels of every line
		addStep(opSync, 0, 0, 16'(syncLowCycles), 0, "syncWidth");

		addStep(opWrite, regMode, modeWord(8'd0, 3'b000, 1'b0, 1'b0), 0, 0, "autoAnim");
		addStep(opAaMark, 0, 0, 0, 0, "autoAnim");
		for (int i = 0; i < 2; i++)
		begin
			addStep(opWaitIpl, 0, 0, 16'h0002, 0, "autoAnim");
			addStep(opWrite, regIrqAck, 16'h0001, 0, 0, "autoAnim");
			addStep(opIpl, 0, 0, 16'h0003, 0, "autoAnim");
		end
		addStep(opAaDelta, 0, 16'd2, 0, 0, "autoAnim");

		addStep(opWrite, regMode, modeWord(8'd0, 3'b000, 1'b0, 1'b1), 0, 0, "aaDisable");
		addStep(opAaMark, 0, 0, 0, 0, "aaDisable");
		addStep(opWaitIpl, 0, 0, 16'h0002, 0, "aaDisable");
		addStep(opWrite, regIrqAck, 16'h0001, 0, 0, "aaDisable");
		addStep(opAaDelta, 0, 16'd0, 0, 0, "aaDisable");

		// Load 1000 with reloadOnLoad, then enable with reloadOnZero
		addStep(opWrite, regMode, modeWord(8'd0, 3'b101, 1'b0, 1'b1), 0, 0, "timer");
		addStep(opWrite, regTimerHigh, 16'h0000, 0, 0, "timer");
		addStep(opWrite, regTimerLow, 16'd1000, 0, 0, "timer");
		addStep(opWrite, regMode, modeWord(8'd0, 3'b101, 1'b1, 1'b1), 0, 0, "timer");
		addStep(opWaitIpl, 0, 0, 16'h0001, 0, "timer");
		addStep(opWrite, regMode, modeWord(8'd0, 3'b101, 1'b0, 1'b1), 0, 0, "timer");
		addStep(opWrite, regIrqAck, 16'h0002, 0, 0, "timer");
		addStep(opIpl, 0, 0, 16'h0003, 0, "timer");
	endtask

	initial
	begin
		nRESET = 1'b0;
		cpuAddr = 3'd0;
		cpuDataIn = '0;
		cpuWr = 1'b0;
		cpuRd = 1'b0;
		buildTable();
		repeat (2) @(posedge CLK_24M);
		@(negedge CLK_24M);
		nRESET = 1'b1;
		@(negedge CLK_24M);
		for (int i = 0; i < steps.size(); i++)
			applyStep(steps[i], stepNames[i]);
		$display("Result: PASSED");
		$finish;
	end

endmodule

// File: tb.f
common/lspcVideoPkg.sv
common/lspcCpuPkg.sv
lspcControl/lspcControl.sv
rtl/rasterCounter.sv
rtl/pixelTimer.sv
rtl/autoAnim.sv
rtl/vramPort.sv
rtl/lspcTop.sv
test/lspcTb_checker.sv
test/lspcTb.sv

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -Wno-fatal --top-module lspcTb -f tb.f -o VlspcTb
./obj_dir/VlspcTb 2>&1 | tee sim.log
if grep -q "Result: FAILED" sim.log; then
	echo "Simulation reported a failure"
	exit 1
fi
if ! grep -q "Result: PASSED" sim.log; then
	echo "Simulation ended without a result"
	exit 1
fi
echo "Simulation finished cleanly"
